/* design/psx_loader_pkg.sv */
//==========================================================
// Shared definitions for the loader path
//   Host bus and memory word widths
//   Download index codes and the download kind
//   Cheat code layout
//==========================================================

`default_nettype none

package psx_loader_pkg;

	// Host download bus
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 16;

	// Memory side
	localparam int RAM_WORD_W   = 32;
	localparam int TRACK_ADDR_W = 9;

	// Index codes sent by the host with each download
	localparam logic [7:0] IDX_BIOS   = 8'd0;
	localparam logic [7:0] IDX_EXE    = 8'd1;
	localparam logic [7:0] IDX_CDINFO = 8'd251;
	localparam logic [7:0] IDX_CODE   = 8'd255;

	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CDINFO,
		DL_CODE
	} dl_kind_t;

	// One cheat code, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* design/ioctl_if.sv */
//==========================================================
// Host download bus with host, sink and packer views
//==========================================================

`timescale 1ns/1ps
`default_nettype none

interface ioctl_if;
	import psx_loader_pkg::*;

	logic                    download;
	logic [7:0]              index;
	logic [IOCTL_ADDR_W-1:0] addr;
	logic [IOCTL_DATA_W-1:0] dout;
	logic                    wr;
	// Stall back to the host
	logic                    wait_req;

	modport host (output download, index, addr, dout, wr, input wait_req);

	modport sink (input download, index, addr, dout, wr);

	modport packer (input download, index, addr, dout, wr, output wait_req);

endinterface

`default_nettype wire

/* design/download_decode.sv */
//==========================================================
// Download decode
//   Index to download kind, registered
//   Core reset during firmware and program loads
//   Program start and cheat clear pulses
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module download_decode (
	input  wire                      clk_1x,
	input  wire                      rst_n,
	ioctl_if.sink                    bus,
	output psx_loader_pkg::dl_kind_t dl_kind,
	output logic                     core_reset,
	output logic                     load_exe,
	output logic                     cheat_clear
);
	import psx_loader_pkg::*;

	dl_kind_t next_kind;
	dl_kind_t prev_kind;

	// Unknown indices fall through to DL_NONE
	always_comb begin
		next_kind = DL_NONE;
		if (bus.download) begin
			case (bus.index)
				IDX_BIOS:   next_kind = DL_BIOS;
				IDX_EXE:    next_kind = DL_EXE;
				IDX_CDINFO: next_kind = DL_CDINFO;
				IDX_CODE:   next_kind = DL_CODE;
				default:    next_kind = DL_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			dl_kind     <= DL_NONE;
			prev_kind   <= DL_NONE;
			core_reset  <= 1'b1;
			load_exe    <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			dl_kind    <= next_kind;
			prev_kind  <= dl_kind;
			// Core held while its memory image is rewritten
			core_reset <= (next_kind == DL_BIOS) || (next_kind == DL_EXE);
			// End of an EXE download starts the program
			load_exe    <= (prev_kind == DL_EXE) && (dl_kind != DL_EXE);
			cheat_clear <= (dl_kind == DL_CODE) && (prev_kind != DL_CODE);
		end
	end

endmodule

`default_nettype wire

/* design/ram_word_packer.sv */
//==========================================================
// RAM word packer
//   Pairs host half-words into 32-bit words
//   Firmware and program words go to RAM with a base offset
//   Host stalled until the RAM acknowledges
//   Track-info words go to the table port, no stall
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module ram_word_packer #(
	parameter int unsigned BIOS_BASE = 2097152,
	parameter int unsigned EXE_BASE  = 4194304
) (
	input  wire                                       clk_1x,
	input  wire                                       rst_n,
	ioctl_if.packer                                   bus,
	input  wire psx_loader_pkg::dl_kind_t             dl_kind,
	input  wire                                       ram_ack,
	output logic                                      ram_req,
	output logic [psx_loader_pkg::IOCTL_ADDR_W-1:0]   ram_addr,
	output logic [psx_loader_pkg::RAM_WORD_W-1:0]     ram_wdata,
	output logic                                      track_write,
	output logic [psx_loader_pkg::TRACK_ADDR_W-1:0]   track_addr
);
	import psx_loader_pkg::*;

	localparam logic [IOCTL_ADDR_W-1:0] BIOS_OFS = IOCTL_ADDR_W'(BIOS_BASE);
	localparam logic [IOCTL_ADDR_W-1:0] EXE_OFS  = IOCTL_ADDR_W'(EXE_BASE);

	logic                    ram_kind;
	logic                    track_kind;
	logic                    low_half;
	logic                    high_half;
	logic [IOCTL_ADDR_W-1:0] base_ofs;
	logic                    wait_q;

	//==========================================================
	// Write decode
	//==========================================================
	assign ram_kind   = (dl_kind == DL_BIOS) || (dl_kind == DL_EXE);
	assign track_kind = (dl_kind == DL_CDINFO);

	// Address bit 1 selects the half
	assign low_half  = bus.wr && !bus.addr[1] && (ram_kind || track_kind);
	assign high_half = bus.wr && bus.addr[1] && (ram_kind || track_kind);

	// Track info keeps the raw address
	always_comb begin
		case (dl_kind)
			DL_BIOS: base_ofs = BIOS_OFS;
			DL_EXE:  base_ofs = EXE_OFS;
			default: base_ofs = '0;
		endcase
	end

	//==========================================================
	// Word and address
	//==========================================================
	always_ff @(posedge clk_1x) begin
		if (low_half) begin
			ram_addr                     <= bus.addr + base_ofs;
			ram_wdata[IOCTL_DATA_W-1:0]  <= bus.dout;
		end
		if (high_half) begin
			ram_wdata[RAM_WORD_W-1:IOCTL_DATA_W] <= bus.dout;
		end
	end

	//==========================================================
	// Request, stall and table write
	//==========================================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			ram_req     <= 1'b0;
			track_write <= 1'b0;
			wait_q      <= 1'b0;
		end else begin
			ram_req     <= high_half && ram_kind;
			track_write <= high_half && track_kind;
			if (!ram_kind) begin
				wait_q <= 1'b0;
			end else if (high_half) begin
				wait_q <= 1'b1;
			end else if (ram_ack) begin
				wait_q <= 1'b0;
			end
		end
	end

	assign bus.wait_req = wait_q;

	// Word index into the track table
	assign track_addr = ram_addr[TRACK_ADDR_W+1:2];

endmodule

`default_nettype wire

/* design/cheat_code_assembler.sv */
//==========================================================
// Cheat code assembler
//   Eight host half-words into one 128-bit code
//   Valid pulse after the last half
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                            clk_1x,
	input  wire                            rst_n,
	ioctl_if.sink                          bus,
	input  wire psx_loader_pkg::dl_kind_t  dl_kind,
	output psx_loader_pkg::cheat_code_t    cheat_code,
	output logic                           cheat_valid
);
	import psx_loader_pkg::*;

	logic code_wr;

	assign code_wr = (dl_kind == DL_CODE) && bus.wr;

	// Offset within the 16-byte code picks field and half
	always_ff @(posedge clk_1x) begin
		if (code_wr) begin
			case (bus.addr[3:0])
				4'd0:  cheat_code.flags[IOCTL_DATA_W-1:0]          <= bus.dout;
				4'd2:  cheat_code.flags[RAM_WORD_W-1:IOCTL_DATA_W]   <= bus.dout;
				4'd4:  cheat_code.addr[IOCTL_DATA_W-1:0]           <= bus.dout;
				4'd6:  cheat_code.addr[RAM_WORD_W-1:IOCTL_DATA_W]    <= bus.dout;
				4'd8:  cheat_code.compare[IOCTL_DATA_W-1:0]        <= bus.dout;
				4'd10: cheat_code.compare[RAM_WORD_W-1:IOCTL_DATA_W] <= bus.dout;
				4'd12: cheat_code.replace[IOCTL_DATA_W-1:0]        <= bus.dout;
				4'd14: cheat_code.replace[RAM_WORD_W-1:IOCTL_DATA_W] <= bus.dout;
				default: ;
			endcase
		end
	end

	// Top half of replace closes the code
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (bus.addr[3:0] == 4'd14);
		end
	end

endmodule

`default_nettype wire

/* design/psx_loader_top.sv */
//==========================================================
// Loader top level
//   Host download ports onto the internal bus
//   Download decode, RAM word packer, cheat assembler
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module psx_loader_top #(
	parameter int unsigned BIOS_BASE = 2097152,
	parameter int unsigned EXE_BASE  = 4194304
) (
	input  wire                                      clk_1x,
	input  wire                                      rst_n,
	// Host download stream
	input  wire                                      ioctl_download,
	input  wire  [7:0]                               ioctl_index,
	input  wire  [psx_loader_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  wire  [psx_loader_pkg::IOCTL_DATA_W-1:0]  ioctl_dout,
	input  wire                                      ioctl_wr,
	output logic                                     ioctl_wait,
	// RAM write port
	output logic                                     ram_req,
	output logic [psx_loader_pkg::IOCTL_ADDR_W-1:0]  ram_addr,
	output logic [psx_loader_pkg::RAM_WORD_W-1:0]    ram_wdata,
	input  wire                                      ram_ack,
	// Track-info table port
	output logic                                     track_write,
	output logic [psx_loader_pkg::TRACK_ADDR_W-1:0]  track_addr,
	// Core controls
	output logic                                     core_reset,
	output logic                                     load_exe,
	output logic                                     cheat_clear,
	output logic                                     cheat_valid,
	output logic [127:0]                             cheat_code
);
	import psx_loader_pkg::*;

	dl_kind_t dl_kind;

	ioctl_if bus ();

	assign bus.download = ioctl_download;
	assign bus.index    = ioctl_index;
	assign bus.addr     = ioctl_addr;
	assign bus.dout     = ioctl_dout;
	assign bus.wr       = ioctl_wr;
	assign ioctl_wait   = bus.wait_req;

	//==========================================================
	// Instances
	//==========================================================
	download_decode u_decode (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.bus         (bus.sink),
		.dl_kind     (dl_kind),
		.core_reset  (core_reset),
		.load_exe    (load_exe),
		.cheat_clear (cheat_clear)
	);

	ram_word_packer #(
		.BIOS_BASE (BIOS_BASE),
		.EXE_BASE  (EXE_BASE)
	) u_packer (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.bus         (bus.packer),
		.dl_kind     (dl_kind),
		.ram_ack     (ram_ack),
		.ram_req     (ram_req),
		.ram_addr    (ram_addr),
		.ram_wdata   (ram_wdata),
		.track_write (track_write),
		.track_addr  (track_addr)
	);

	cheat_code_assembler u_cheat (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.bus         (bus.sink),
		.dl_kind     (dl_kind),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

endmodule

`default_nettype wire

/* tests/tb_psx_loader.sv */
//==========================================================
// Testbench for the loader top level
//   Host download driver and RAM responder
//   Scoreboard queues and protocol assertions
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_psx_loader;
	import psx_loader_pkg::*;

	localparam int BIOS_BASE  = 2097152;
	localparam int EXE_BASE   = 4194304;
	localparam int MAX_CYCLES = 6000;

	logic         clk_1x = 1'b0;
	logic         rst_n;
	logic         ioctl_download;
	logic [7:0]   ioctl_index;
	logic [26:0]  ioctl_addr;
	logic [15:0]  ioctl_dout;
	logic         ioctl_wr;
	logic         ioctl_wait;
	logic         ram_req;
	logic [26:0]  ram_addr;
	logic [31:0]  ram_wdata;
	logic         ram_ack;
	logic         track_write;
	logic [8:0]   track_addr;
	logic         core_reset;
	logic         load_exe;
	logic         cheat_clear;
	logic         cheat_valid;
	logic [127:0] cheat_code;

	// Expected writes, {addr, data} for RAM and {table addr, data} for tracks
	logic [58:0]  ram_q[$];
	logic [40:0]  track_q[$];
	logic [127:0] cheat_q[$];

	integer seed = 84;
	int cycles = 0;
	int errors = 0;
	int start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// Sampled history for the pulse and stall models
	logic       rst_q = 1'b0;
	logic       bios_q = 1'b0;
	logic       hold = 1'b0;
	logic [2:0] exe_h = 3'b000;
	logic [2:0] code_h = 3'b000;

	psx_loader_top #(
		.BIOS_BASE (BIOS_BASE),
		.EXE_BASE  (EXE_BASE)
	) UUT (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ioctl_wait     (ioctl_wait),
		.ram_req        (ram_req),
		.ram_addr       (ram_addr),
		.ram_wdata      (ram_wdata),
		.ram_ack        (ram_ack),
		.track_write    (track_write),
		.track_addr     (track_addr),
		.core_reset     (core_reset),
		.load_exe       (load_exe),
		.cheat_clear    (cheat_clear),
		.cheat_valid    (cheat_valid),
		.cheat_code     (cheat_code)
	);

	always #20 clk_1x = ~clk_1x;

	task automatic show_mismatch(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic count_failure(input string msg);
		$display("ERROR at %0d ns: %s", $time, msg);
		errors++;
	endtask

	//==========================================================
	// Protocol assertions and scoreboards
	//==========================================================
	always @(posedge clk_1x) begin
		logic [58:0]  ram_exp;
		logic [40:0]  track_exp;
		logic [127:0] cheat_exp;
		cycles = cycles + 1;
		if (cycles > 1) begin
			assert (core_reset === (!rst_q || bios_q))
				else show_mismatch($sformatf("core_reset is %b", core_reset));
		end
		if (cycles > 1 && !rst_q) begin
			assert (!ram_req && !ioctl_wait && !track_write && !load_exe
					&& !cheat_clear && !cheat_valid)
				else show_mismatch("control output active during reset");
		end
		if (rst_q) begin
			assert (ioctl_wait === (ram_req || hold))
				else show_mismatch($sformatf("ioctl_wait is %b", ioctl_wait));
			assert (load_exe === (exe_h[2] && !exe_h[1]))
				else show_mismatch($sformatf("load_exe is %b", load_exe));
			assert (cheat_clear === (code_h[1] && !code_h[2]))
				else show_mismatch($sformatf("cheat_clear is %b", cheat_clear));
			assert (!(ioctl_wr && ioctl_wait))
				else count_failure("host wrote a half-word during a stall");
			if (ram_req) begin
				if (ram_q.size() == 0) begin
					count_failure("ram_req seen with no RAM write expected");
				end else begin
					ram_exp = ram_q.pop_front();
					assert ({ram_addr, ram_wdata} === ram_exp)
						else show_mismatch($sformatf("RAM write %h:%h, expected %h:%h",
							ram_addr, ram_wdata, ram_exp[58:32], ram_exp[31:0]));
				end
			end
			if (track_write) begin
				if (track_q.size() == 0) begin
					count_failure("track_write seen with no table write expected");
				end else begin
					track_exp = track_q.pop_front();
					assert ({track_addr, ram_wdata} === track_exp)
						else show_mismatch($sformatf("track write %h:%h, expected %h:%h",
							track_addr, ram_wdata, track_exp[40:32], track_exp[31:0]));
				end
			end
			if (cheat_valid) begin
				if (cheat_q.size() == 0) begin
					count_failure("cheat_valid seen with no code expected");
				end else begin
					cheat_exp = cheat_q.pop_front();
					assert (cheat_code === cheat_exp)
						else show_mismatch($sformatf("cheat code %h, expected %h",
							cheat_code, cheat_exp));
				end
			end
		end
		// Stall holds from the request until the acknowledge is seen
		if (!rst_n) begin
			hold = 1'b0;
		end else if (ram_req) begin
			hold = 1'b1;
		end else if (ram_ack) begin
			hold = 1'b0;
		end
		rst_q  = rst_n;
		bios_q = ioctl_download && (ioctl_index == IDX_BIOS || ioctl_index == IDX_EXE);
		exe_h  = {exe_h[1:0], rst_n && ioctl_download && ioctl_index == IDX_EXE};
		code_h = {code_h[1:0], rst_n && ioctl_download && ioctl_index == IDX_CODE};
	end

	// RAM responder, one acknowledge 1 to 6 cycles after each request
	initial begin
		int delay;
		ram_ack <= 1'b0;
		forever begin
			@(posedge clk_1x);
			if (ram_req) begin
				delay = 1 + ((($random(seed) % 6) + 6) % 6);
				repeat (delay - 1) @(posedge clk_1x);
				ram_ack <= 1'b1;
				@(posedge clk_1x);
				ram_ack <= 1'b0;
			end
		end
	end

	initial begin
		wait (cycles >= MAX_CYCLES);
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	//==========================================================
	// Host driver
	//==========================================================
	task automatic send_half(input logic [26:0] addr, input logic [15:0] data);
		@(posedge clk_1x);
		while (ioctl_wait) begin
			@(posedge clk_1x);
		end
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic send_word(input logic [26:0] addr, input logic [31:0] word);
		send_half(addr, word[15:0]);
		send_half(addr | 27'd2, word[31:16]);
	endtask

	task automatic begin_download(input logic [7:0] idx);
		@(posedge clk_1x);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_1x);
	endtask

	// Last stall must clear before the download flag drops
	task automatic end_download();
		repeat (2) @(posedge clk_1x);
		while (ioctl_wait) begin
			@(posedge clk_1x);
		end
		ioctl_download <= 1'b0;
		repeat (8) @(posedge clk_1x);
	endtask

	task automatic ram_download(input logic [7:0] idx, input logic [26:0] start,
			input int count, input int base);
		logic [31:0] word;
		logic [26:0] addr;
		begin_download(idx);
		for (int i = 0; i < count; i++) begin
			word = $random(seed);
			addr = start + 27'(4 * i);
			ram_q.push_back({27'(addr + base), word});
			send_word(addr, word);
		end
		end_download();
	endtask

	task automatic track_download(input logic [26:0] start, input int count);
		logic [31:0] word;
		logic [26:0] addr;
		begin_download(IDX_CDINFO);
		for (int i = 0; i < count; i++) begin
			word = $random(seed);
			addr = start + 27'(4 * i);
			track_q.push_back({addr[10:2], word});
			send_word(addr, word);
		end
		end_download();
	endtask

	// Halves go out flags low first, replace high last
	task automatic cheat_download(input int count);
		logic [31:0] field [4];
		logic [15:0] half;
		begin_download(IDX_CODE);
		for (int j = 0; j < count; j++) begin
			for (int f = 0; f < 4; f++) begin
				field[f] = $random(seed);
			end
			cheat_q.push_back({field[0], field[1], field[2], field[3]});
			for (int k = 0; k < 8; k++) begin
				half = (k % 2) ? field[k / 2][31:16] : field[k / 2][15:0];
				send_half(27'(16 * j + 2 * k), half);
			end
		end
		end_download();
	endtask

	task automatic close_test(input string name);
		int errs;
		if (ram_q.size() + track_q.size() + cheat_q.size() != 0) begin
			count_failure($sformatf("%0d expected writes never appeared",
				ram_q.size() + track_q.size() + cheat_q.size()));
			ram_q.delete();
			track_q.delete();
			cheat_q.delete();
		end
		errs = errors - start_errors;
		start_errors = errors;
		tests_run++;
		if (errs == 0) begin
			$display("Test %0d %s: PASS", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAIL with %0d errors", tests_run, name, errs);
		end
	endtask

	//==========================================================
	// Test sequence
	//==========================================================
	initial begin
		logic [31:0] junk;
		rst_n          <= 1'b0;
		ioctl_download <= 1'b0;
		ioctl_index    <= 8'd0;
		ioctl_addr     <= '0;
		ioctl_dout     <= '0;
		ioctl_wr       <= 1'b0;
		repeat (10) @(posedge clk_1x);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_1x);
		start_errors = errors;

		ram_download(IDX_BIOS, 27'h0, 16, BIOS_BASE);
		close_test("BIOS download");
		ram_download(IDX_EXE, 27'h800, 8, EXE_BASE);
		close_test("EXE download");
		// Start near the top of the table so the word index wraps
		track_download(27'h7f0, 8);
		close_test("Track-info download");
		cheat_download(3);
		close_test("Cheat download");

		// Offsets 2 to 14 would close a cheat code if decoded
		begin_download(8'd2);
		for (int i = 0; i < 4; i++) begin
			junk = $random(seed);
			send_word(27'(4 * i), junk);
		end
		end_download();
		rst_n <= 1'b0;
		repeat (10) @(posedge clk_1x);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_1x);
		close_test("Unknown index and reset");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
design/psx_loader_pkg.sv
design/ioctl_if.sv
design/download_decode.sv
design/ram_word_packer.sv
design/cheat_code_assembler.sv
design/psx_loader_top.sv
tests/tb_psx_loader.sv
